//--- hw/coreReadSeq.sv
// Core-side read sequencer that delays data-valid strobes and steps the core word address.
`timescale 1ns/10ps
`include "memCtl_macros.svh"

module coreReadSeq import memCtlPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  logic    aChangeComing,
  input  logic    bChangeComing,
  input  logic    memDataValidA,
  input  logic    memDataValidB,
  input  logic    nxmDataVal,
  input  logic    started,
  input  logic    readStart,
  input  logic    done,
  memReqIf.core   req,
  output logic    coreDataValid,
  output wordAdrT coreAdr,
  output logic    coreRdInProg,
  output logic    coreBusy
);

  logic                     rdOpen;
  logic                     rdWindow;
  logic                     dataValidEvent;
  logic                     dataValidStage1;
  logic [`MEMCTL_CNT_W-1:0] wordTarget;
  logic [`MEMCTL_CNT_W-1:0] wordCount;
  logic                     lastWord;

  // Data may arrive during the read start or later while core words are still owed.
  assign rdWindow = (started && rdOpen) || coreRdInProg;

  assign dataValidEvent = rdWindow &&
                          ((memDataValidA && aChangeComing) ||
                           (memDataValidB && bChangeComing) ||
                           (nxmDataVal && (aChangeComing || bChangeComing)));

  assign lastWord = coreDataValid && coreRdInProg &&
                    ((wordCount + 1'b1) == wordTarget);

  // Two register stages, so a new event can enter every cycle.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dataValidStage1 <= 1'b0;
      coreDataValid   <= 1'b0;
    end else begin
      dataValidStage1 <= dataValidEvent;
      coreDataValid   <= dataValidStage1;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rdOpen       <= 1'b0;
      coreRdInProg <= 1'b0;
      wordCount    <= '0;
      wordTarget   <= '0;
    end else begin
      if (readStart) begin
        rdOpen <= 1'b1;
      end else if (done) begin
        rdOpen <= 1'b0;
      end
      if (readStart) begin
        coreRdInProg <= 1'b1;
        wordCount    <= '0;
        wordTarget   <= countWords(req.rqMask);
      end else if (coreDataValid && coreRdInProg) begin
        wordCount <= wordCount + 1'b1;
        if (lastWord) begin
          coreRdInProg <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (readStart) begin
      coreAdr <= req.adr;
    end else if (coreDataValid && coreRdInProg) begin
      coreAdr <= coreAdr + 1'b1;
    end
  end

  assign coreBusy = readStart || (coreRdInProg && !lastWord);

endmodule

//--- hw/memCtlPkg.sv
// Shared types and helper functions of the memory controller, imported by every RTL file.
`include "memCtl_macros.svh"

package memCtlPkg;

  // Bit n requests word n of the block.
  typedef logic [`MEMCTL_NWORDS-1:0] rqMaskT;

  // Word address within the block. Arithmetic wraps at the block size.
  typedef logic [`MEMCTL_ADR_W-1:0] wordAdrT;

  typedef enum logic {
    phaseA,
    phaseB
  } busPhaseT;

  typedef enum logic [1:0] {
    idle,
    waitPhase,
    startedA,
    startedB
  } startStateT;

  // Number of words requested by a mask.
  function automatic logic [`MEMCTL_CNT_W-1:0] countWords(rqMaskT mask);
    logic [`MEMCTL_CNT_W-1:0] total;
    total = '0;
    for (int i = 0; i < `MEMCTL_NWORDS; i++) begin
      total = total + `MEMCTL_CNT_W'(mask[i]);
    end
    return total;
  endfunction

endpackage

//--- hw/memCtlTop.sv
// Top level of the memory controller, which joins the phase timer, latch and sequencers.
`timescale 1ns/10ps

module memCtlTop import memCtlPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     startRq,
  input  logic     rdRqIn,
  input  logic     wrRqIn,
  input  rqMaskT   rqMaskIn,
  input  wordAdrT  adrIn,
  input  logic     parIn,
  input  logic     forceBadPar,
  input  logic     memAcknA,
  input  logic     memAcknB,
  input  logic     nxmAckn,
  input  logic     memDataValidA,
  input  logic     memDataValidB,
  input  logic     nxmDataVal,
  output logic     busy,
  output logic     memAdrPar,
  output rqMaskT   memRq,
  output logic     memRdRq,
  output logic     memWrRq,
  output logic     memStartA,
  output logic     memStartB,
  output logic     coreDataValid,
  output wordAdrT  coreAdr,
  output logic     coreRdInProg,
  output logic     coreBusy,
  output busPhaseT phase,
  output logic     aChangeComing,
  output logic     bChangeComing
);

  logic started;
  logic readStart;
  logic done;

  memReqIf req ();

  phaseTimer phaseTimer_i (
    .clk           (clk),
    .rstN          (rstN),
    .phase         (phase),
    .aChangeComing (aChangeComing),
    .bChangeComing (bChangeComing)
  );

  requestLatch requestLatch_i (
    .clk         (clk),
    .rstN        (rstN),
    .startRq     (startRq),
    .rdRqIn      (rdRqIn),
    .wrRqIn      (wrRqIn),
    .rqMaskIn    (rqMaskIn),
    .adrIn       (adrIn),
    .parIn       (parIn),
    .forceBadPar (forceBadPar),
    .req         (req.latch),
    .busy        (busy),
    .memAdrPar   (memAdrPar)
  );

  memStartCtl memStartCtl_i (
    .clk           (clk),
    .rstN          (rstN),
    .aChangeComing (aChangeComing),
    .bChangeComing (bChangeComing),
    .memAcknA      (memAcknA),
    .memAcknB      (memAcknB),
    .nxmAckn       (nxmAckn),
    .req           (req.start),
    .memStartA     (memStartA),
    .memStartB     (memStartB),
    .started       (started),
    .readStart     (readStart),
    .done          (done)
  );

  coreReadSeq coreReadSeq_i (
    .clk           (clk),
    .rstN          (rstN),
    .aChangeComing (aChangeComing),
    .bChangeComing (bChangeComing),
    .memDataValidA (memDataValidA),
    .memDataValidB (memDataValidB),
    .nxmDataVal    (nxmDataVal),
    .started       (started),
    .readStart     (readStart),
    .done          (done),
    .req           (req.core),
    .coreDataValid (coreDataValid),
    .coreAdr       (coreAdr),
    .coreRdInProg  (coreRdInProg),
    .coreBusy      (coreBusy)
  );

  assign memRq   = req.rqMask;
  assign memRdRq = req.rdRq;
  assign memWrRq = req.wrRq;

endmodule

//--- hw/memCtl_macros.svh
// Width and timing constants for the memory controller, included by the package and RTL.
`ifndef MEMCTL_MACROS_SVH
`define MEMCTL_MACROS_SVH

// Words in one memory block. There is one request bit per word.
`define MEMCTL_NWORDS 4

// Width of a word address within the block.
`define MEMCTL_ADR_W 2

// Clock cycles in one A or B bus phase.
`define MEMCTL_PHASE_CYCLES 4

// Width of the phase cycle counter.
`define MEMCTL_PHASE_CNT_W 2

// Width of a word count, holding 0 up to MEMCTL_NWORDS.
`define MEMCTL_CNT_W 3

`endif

//--- hw/memReqIf.sv
// Held memory request, shared by the request latch, the start control and the core sequencer.
`timescale 1ns/10ps

interface memReqIf import memCtlPkg::*; ();

  logic    hold;
  rqMaskT  rqMask;
  logic    rdRq;
  logic    wrRq;
  wordAdrT adr;
  logic    firstWord;
  logic    releaseRq;

  // The latch owns the request and only takes the release back.
  modport latch (
    output hold, rqMask, rdRq, wrRq, adr, firstWord,
    input  releaseRq
  );

  // The start control loads its word mask on the first cycle and frees the latch when done.
  modport start (
    input  hold, rqMask, rdRq, firstWord,
    output releaseRq
  );

  // The core side only looks at the request.
  modport core (
    input rqMask, adr
  );

endinterface

//--- hw/memStartCtl.sv
// Memory start sequencer that times the start to a bus phase and counts the acknowledges.
`timescale 1ns/10ps

module memStartCtl import memCtlPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   aChangeComing,
  input  logic   bChangeComing,
  input  logic   memAcknA,
  input  logic   memAcknB,
  input  logic   nxmAckn,
  memReqIf.start req,
  output logic   memStartA,
  output logic   memStartB,
  output logic   started,
  output logic   readStart,
  output logic   done
);

  startStateT state;
  startStateT stateNext;
  rqMaskT     wordsLeft;
  rqMaskT     wordsAfterAckn;
  logic       acknPulse;
  logic       lastAckn;
  logic       startNow;
  logic       clearPulse;

  assign memStartA = (state == startedA);
  assign memStartB = (state == startedB);
  assign started   = memStartA || memStartB;

  // Each start only listens to acknowledges on the strobe of its own phase.
  assign acknPulse = (memStartA && (memAcknA || nxmAckn) && aChangeComing) ||
                     (memStartB && (memAcknB || nxmAckn) && bChangeComing);

  // Dropping the lowest set bit retires the word being acknowledged.
  assign wordsAfterAckn = wordsLeft & (wordsLeft - 1'b1);
  assign lastAckn       = acknPulse && (wordsAfterAckn == '0);

  assign startNow = (state == waitPhase) && (aChangeComing || bChangeComing);

  always_comb begin
    stateNext = state;
    case (state)
      idle: begin
        if (req.firstWord && req.hold) begin
          stateNext = waitPhase;
        end
      end
      waitPhase: begin
        if (aChangeComing) begin
          stateNext = startedA;
        end else if (bChangeComing) begin
          stateNext = startedB;
        end
      end
      startedA, startedB: begin
        if (lastAckn) begin
          stateNext = idle;
        end
      end
      default: stateNext = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state      <= idle;
      wordsLeft  <= '0;
      readStart  <= 1'b0;
      clearPulse <= 1'b0;
    end else begin
      state      <= stateNext;
      readStart  <= startNow && req.rdRq;
      clearPulse <= lastAckn;
      if (req.firstWord) begin
        wordsLeft <= req.rqMask;
      end else if (acknPulse) begin
        wordsLeft <= wordsAfterAckn;
      end
    end
  end

  assign req.releaseRq = clearPulse;
  assign done          = clearPulse;

endmodule

//--- hw/phaseTimer.sv
// Bus phase generator that alternates A and B phases and flags the last cycle of each.
`timescale 1ns/10ps
`include "memCtl_macros.svh"

module phaseTimer import memCtlPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  output busPhaseT phase,
  output logic     aChangeComing,
  output logic     bChangeComing
);

  localparam logic [`MEMCTL_PHASE_CNT_W-1:0] LastCount =
    `MEMCTL_PHASE_CNT_W'(`MEMCTL_PHASE_CYCLES - 1);

  logic [`MEMCTL_PHASE_CNT_W-1:0] phaseCount;
  logic                           lastCycle;

  assign lastCycle = (phaseCount == LastCount);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      phaseCount <= '0;
    end else if (lastCycle) begin
      phaseCount <= '0;
    end else begin
      phaseCount <= phaseCount + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      phase <= phaseA;
    end else if (lastCycle) begin
      phase <= (phase == phaseA) ? phaseB : phaseA;
    end
  end

  // The last cycle of a B phase announces the coming A phase, and the other way round.
  assign aChangeComing = lastCycle && (phase == phaseB);
  assign bChangeComing = lastCycle && (phase == phaseA);

endmodule

//--- hw/requestLatch.sv
// Request holding register that captures a start request and drives the memory address parity.
`timescale 1ns/10ps

module requestLatch import memCtlPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  logic    startRq,
  input  logic    rdRqIn,
  input  logic    wrRqIn,
  input  rqMaskT  rqMaskIn,
  input  wordAdrT adrIn,
  input  logic    parIn,
  input  logic    forceBadPar,
  memReqIf.latch  req,
  output logic    busy,
  output logic    memAdrPar
);

  logic accept;
  logic parHold;
  logic forceBadParHold;

  // A start is only taken while nothing is held.
  assign accept = startRq && !req.hold;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      req.hold      <= 1'b0;
      req.firstWord <= 1'b0;
      req.rqMask    <= '0;
      req.rdRq      <= 1'b0;
      req.wrRq      <= 1'b0;
    end else begin
      req.firstWord <= accept;
      if (accept) begin
        req.hold   <= 1'b1;
        req.rqMask <= rqMaskIn;
        req.rdRq   <= rdRqIn;
        req.wrRq   <= wrRqIn;
      end else if (req.releaseRq) begin
        req.hold <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req.adr         <= adrIn;
      parHold         <= parIn;
      forceBadParHold <= forceBadPar;
    end
  end

  assign busy = req.hold;

  // Parity covers the incoming address parity, both request types, the mask and the word address.
  assign memAdrPar = parHold ^ req.rdRq ^ req.wrRq ^ (^req.rqMask) ^ (^req.adr) ^
                     forceBadParHold;

endmodule

//--- run.sh
#!/bin/sh
# Builds the memory controller testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
  --top-module memCtlTb -f sim.f -o memCtlSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/memCtlSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q -F "*** TEST FAILED ***" "$LOG"; then
  exit 1
fi
exit 0

//--- sim.f
+incdir+hw
hw/memCtlPkg.sv
hw/memReqIf.sv
hw/phaseTimer.sv
hw/requestLatch.sv
hw/memStartCtl.sv
hw/coreReadSeq.sv
hw/memCtlTop.sv
testbench/memCtlTb.sv

//--- testbench/memCtlTb.sv
// Directed testbench for memCtlTop that models the memory side and checks the core side.
`timescale 1ns/10ps

module memCtlTb import memCtlPkg::*; ();

  logic        clk;
  logic        rstN;
  logic        startRq;
  logic        rdRqIn;
  logic        wrRqIn;
  rqMaskT      rqMaskIn;
  wordAdrT     adrIn;
  logic        parIn;
  logic        forceBadPar;
  logic        memAcknA;
  logic        memAcknB;
  logic        nxmAckn;
  logic        memDataValidA;
  logic        memDataValidB;
  logic        nxmDataVal;
  logic        busy;
  logic        memAdrPar;
  rqMaskT      memRq;
  logic        memRdRq;
  logic        memWrRq;
  logic        memStartA;
  logic        memStartB;
  logic        coreDataValid;
  wordAdrT     coreAdr;
  logic        coreRdInProg;
  logic        coreBusy;
  busPhaseT    phase;
  logic        aChangeComing;
  logic        bChangeComing;

  int          errorCount;
  int          failedTests;
  int          testErrors;
  int          cycleNo;
  int          coreWords;
  int          dvEvents[$];
  wordAdrT     expAdr;
  logic        rdInProgSeen;
  logic [15:0] lfsr;

  memCtlTop dut_i (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // Pairs every data-valid strobe with the core data valid that should follow two cycles later.
  always @(negedge clk) begin
    cycleNo = cycleNo + 1;
    if (coreRdInProg) begin
      rdInProgSeen = 1'b1;
    end
    if ((memStartA || memStartB) &&
        ((memDataValidA && aChangeComing) || (memDataValidB && bChangeComing) ||
         (nxmDataVal && (aChangeComing || bChangeComing)))) begin
      dvEvents.push_back(cycleNo);
    end
    if (coreDataValid) begin
      coreWords = coreWords + 1;
      checkValue("coreAdr", 32'(expAdr), 32'(coreAdr));
      expAdr = expAdr + wordAdrT'(1);
      if (dvEvents.size() == 0) begin
        $display("Core data valid at %0d ns came without a data-valid strobe before it", $time);
        errorCount++;
      end else begin
        checkValue("coreDataValid delay", dvEvents.pop_front() + 2, cycleNo);
      end
    end
  end

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
      errorCount++;
    end
  endtask

  // Taps 16, 14, 13 and 11 give a maximal-length sequence.
  function automatic logic [15:0] lfsrStep(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic randomBits(input int count, output logic [3:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr  = lfsrStep(lfsr);
      value = {value[2:0], lfsr[0]};
    end
  endtask

  function automatic int bitCount(input rqMaskT mask);
    int total;
    total = 0;
    for (int i = 0; i < $bits(mask); i++) begin
      total = total + int'(mask[i]);
    end
    return total;
  endfunction

  task automatic waitStrobe(input busPhaseT which);
    logic found;
    found = 1'b0;
    for (int n = 0; n < 12 && !found; n++) begin
      @(negedge clk);
      found = (which == phaseA) ? aChangeComing : bChangeComing;
    end
    if (!found) begin
      $display("Timed out at %0d ns waiting for the %s strobe", $time, which.name());
      errorCount++;
    end
  endtask

  task automatic waitIdle();
    logic found;
    found = 1'b0;
    for (int n = 0; n < 20 && !found; n++) begin
      @(negedge clk);
      found = !busy && !coreRdInProg;
    end
    if (!found) begin
      $display("Timed out at %0d ns waiting for busy and read in progress to clear", $time);
      errorCount++;
    end
    checkValue("memStartA", 0, memStartA);
    checkValue("memStartB", 0, memStartB);
    checkValue("coreBusy", 0, coreBusy);
  endtask

  task automatic clearMonitor(input wordAdrT adr);
    expAdr       = adr;
    coreWords    = 0;
    rdInProgSeen = 1'b0;
    dvEvents.delete();
  endtask

  task automatic issueRequest(input logic rd, input rqMaskT mask, input wordAdrT adr,
                              input logic par, input logic badPar);
    @(posedge clk);
    startRq     <= 1'b1;
    rdRqIn      <= rd;
    wrRqIn      <= !rd;
    rqMaskIn    <= mask;
    adrIn       <= adr;
    parIn       <= par;
    forceBadPar <= badPar;
    @(posedge clk);
    startRq     <= 1'b0;
  endtask

  // Memory model. Each word is answered on the own phase's strobe, four cycles after the other one.
  task automatic answerRequest(input busPhaseT startPhase, input logic rd, input logic nxm,
                               input int words);
    busPhaseT other;
    other = (startPhase == phaseA) ? phaseB : phaseA;
    for (int w = 0; w < words; w++) begin
      waitStrobe(other);
      repeat (4) @(posedge clk);
      if (nxm) begin
        nxmAckn    <= 1'b1;
        nxmDataVal <= rd;
      end else if (startPhase == phaseA) begin
        memAcknA      <= 1'b1;
        memDataValidA <= rd;
      end else begin
        memAcknB      <= 1'b1;
        memDataValidB <= rd;
      end
      @(negedge clk);
      checkValue("own phase strobe", 1,
                 (startPhase == phaseA) ? aChangeComing : bChangeComing);
      checkValue("memStart before last ack", 1, memStartA || memStartB);
      checkValue("coreBusy", rd, coreBusy);
      @(posedge clk);
      memAcknA      <= 1'b0;
      memAcknB      <= 1'b0;
      nxmAckn       <= 1'b0;
      memDataValidA <= 1'b0;
      memDataValidB <= 1'b0;
      nxmDataVal    <= 1'b0;
    end
  endtask

  task automatic waitStart();
    logic found;
    found = 1'b0;
    @(negedge clk);
    checkValue("busy", 1, busy);
    for (int n = 0; n < 8 && !found; n++) begin
      found = memStartA || memStartB;
      if (!found) begin
        @(negedge clk);
      end
    end
    if (!found) begin
      $display("No memory start came within 8 cycles of busy at %0d ns", $time);
      errorCount++;
    end
  endtask

  task automatic runTransfer(input logic rd, input rqMaskT mask, input wordAdrT adr,
                             input logic par, input logic badPar, input logic nxm,
                             input busPhaseT startPhase);
    logic expPar;
    int   words;
    words  = bitCount(mask);
    expPar = par ^ rd ^ !rd ^ (^mask) ^ (^adr) ^ badPar;
    // A request made right after the other phase's strobe starts in the wanted phase.
    waitStrobe((startPhase == phaseA) ? phaseB : phaseA);
    clearMonitor(adr);
    issueRequest(rd, mask, adr, par, badPar);
    waitStart();
    checkValue("memStartA", startPhase == phaseA, memStartA);
    checkValue("memStartB", startPhase == phaseB, memStartB);
    checkValue("coreBusy at start", rd, coreBusy);
    checkValue("memRq", mask, memRq);
    checkValue("memRdRq", rd, memRdRq);
    checkValue("memWrRq", !rd, memWrRq);
    checkValue("memAdrPar", expPar, memAdrPar);
    answerRequest(startPhase, rd, nxm, words);
    waitIdle();
    checkValue("core word count", rd ? words : 0, coreWords);
    checkValue("coreRdInProg seen", rd, rdInProgSeen);
    checkValue("unanswered data-valid strobes", 0, dvEvents.size());
  endtask

  task automatic testReset();
    int       aCount;
    int       bCount;
    int       lastA;
    busPhaseT expPhase;
    aCount = 0;
    bCount = 0;
    lastA  = -1;
    @(negedge clk);
    checkValue("busy", 0, busy);
    checkValue("memStartA", 0, memStartA);
    checkValue("memStartB", 0, memStartB);
    checkValue("memRq", 0, memRq);
    checkValue("memRdRq", 0, memRdRq);
    checkValue("memWrRq", 0, memWrRq);
    checkValue("coreDataValid", 0, coreDataValid);
    checkValue("coreRdInProg", 0, coreRdInProg);
    checkValue("coreBusy", 0, coreBusy);
    checkValue("aChangeComing", 0, aChangeComing);
    checkValue("bChangeComing", 0, bChangeComing);
    checkValue("phase", phaseA, phase);
    for (int i = 0; i < 24; i++) begin
      @(negedge clk);
      // Cycle i + 1 after reset. Four cycles of A, then four of B.
      expPhase = (((i + 1) / 4) % 2 == 0) ? phaseA : phaseB;
      checkValue("phase", expPhase, phase);
      checkValue("aChangeComing", (i + 1) % 8 == 7, aChangeComing);
      checkValue("bChangeComing", (i + 1) % 8 == 3, bChangeComing);
      if (aChangeComing) begin
        if (lastA >= 0) begin
          checkValue("aChangeComing spacing", 8, i - lastA);
        end
        lastA  = i;
        aCount = aCount + 1;
      end
      if (bChangeComing) begin
        bCount = bCount + 1;
      end
    end
    checkValue("aChangeComing count", 3, aCount);
    checkValue("bChangeComing count", 3, bCount);
  endtask

  task automatic testRandomReads(input logic nxm, input int count);
    logic [3:0] bits;
    rqMaskT     mask;
    wordAdrT    adr;
    for (int i = 0; i < count; i++) begin
      randomBits(4, bits);
      mask = (bits == 4'b0000) ? 4'b0001 : bits;
      randomBits(2, bits);
      adr = bits[1:0];
      runTransfer(1'b1, mask, adr, i[0], 1'b0, nxm, (i % 2 == 0) ? phaseA : phaseB);
    end
  endtask

  task automatic testBusy();
    waitStrobe(phaseB);
    clearMonitor(2'd1);
    issueRequest(1'b1, 4'b0110, 2'd1, 1'b0, 1'b0);
    @(posedge clk);
    startRq  <= 1'b1;
    rqMaskIn <= 4'b1001;
    @(posedge clk);
    startRq  <= 1'b0;
    @(negedge clk);
    checkValue("memRq while busy", 4'b0110, memRq);
    answerRequest(phaseA, 1'b1, 1'b0, 2);
    waitIdle();
    checkValue("core word count", 2, coreWords);
    runTransfer(1'b1, 4'b1001, 2'd3, 1'b1, 1'b0, 1'b0, phaseB);
  endtask

  task automatic finishTest(input string name);
    if (errorCount == testErrors) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errorCount - testErrors);
      failedTests++;
    end
    testErrors = errorCount;
  endtask

  initial begin
    rstN          = 1'b0;
    startRq       = 1'b0;
    rdRqIn        = 1'b0;
    wrRqIn        = 1'b0;
    rqMaskIn      = '0;
    adrIn         = '0;
    parIn         = 1'b0;
    forceBadPar   = 1'b0;
    memAcknA      = 1'b0;
    memAcknB      = 1'b0;
    nxmAckn       = 1'b0;
    memDataValidA = 1'b0;
    memDataValidB = 1'b0;
    nxmDataVal    = 1'b0;
    errorCount    = 0;
    failedTests   = 0;
    testErrors    = 0;
    cycleNo       = 0;
    lfsr          = 16'd59734;
    clearMonitor(2'd0);
    repeat (8) @(posedge clk);
    rstN <= 1'b1;

    testReset();
    finishTest("reset state");
    runTransfer(1'b1, 4'b0100, 2'd2, 1'b0, 1'b0, 1'b0, phaseA);
    finishTest("single-word read");
    testRandomReads(1'b0, 6);
    finishTest("multi-word reads");
    runTransfer(1'b0, 4'b1111, 2'd0, 1'b0, 1'b0, 1'b0, phaseB);
    runTransfer(1'b0, 4'b1010, 2'd3, 1'b1, 1'b0, 1'b0, phaseA);
    finishTest("write");
    runTransfer(1'b1, 4'b0011, 2'd2, 1'b1, 1'b1, 1'b0, phaseA);
    runTransfer(1'b1, 4'b0011, 2'd2, 1'b1, 1'b0, 1'b0, phaseB);
    testRandomReads(1'b1, 2);
    finishTest("parity and NXM");
    testBusy();
    finishTest("busy behavior");

    $display("Tests run: 6, tests failed: %0d, errors: %0d", failedTests, errorCount);
    if (errorCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
